// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - design/rv_exec_pkg.sv
  - design/brcomp.sv
  - design/shifter.sv
  - design/alu.sv
  - design/inst_decoder.sv
  - design/regfile.sv
  - design/exec_core.sv
  - target: test
    files:
      - test/tb_exec_core.sv

// ==== design/alu.sv ====
`timescale 1ns/1ns

module alu import rv_exec_pkg::*; #(
  parameter int XLEN = rv_exec_pkg::XLEN
) (
  input  logic [XLEN-1:0] i_op_a,
  input  logic [XLEN-1:0] i_op_b,
  input  alu_op_e         i_alu_op,
  output logic [XLEN-1:0] o_alu_data
);

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] rd_add;
  logic [XLEN-1:0] rd_sub;
  logic [XLEN-1:0] rd_and;
  logic [XLEN-1:0] rd_or;
  logic [XLEN-1:0] rd_xor;
  logic [XLEN-1:0] rd_shift;
  logic            slt;
  logic            sltu;
  shift_op_e       shift_op;

  // ========================================
  // Single-operator results
  // ========================================
  assign rd_add = i_op_a + i_op_b;
  assign rd_sub = i_op_a - i_op_b;
  assign rd_and = i_op_a & i_op_b;
  assign rd_or  = i_op_a | i_op_b;
  assign rd_xor = i_op_a ^ i_op_b;

  always_comb begin
    case (i_alu_op)
      ALU_SLL: shift_op = SH_SLL;
      ALU_SRA: shift_op = SH_SRA;
      default: shift_op = SH_SRL;
    endcase
  end

  shifter #(.XLEN(XLEN)) u_shifter (
    .i_data     (i_op_a),
    .i_shamt    (i_op_b[SHW-1:0]),  // Low bits only
    .i_shift_op (shift_op),
    .o_data     (rd_shift)
  );

  brcomp #(.XLEN(XLEN)) u_slt (
    .i_rs1_data (i_op_a),
    .i_rs2_data (i_op_b),
    .i_br_un    (1'b0),
    .o_br_less  (slt),
    .o_br_equal ()
  );

  brcomp #(.XLEN(XLEN)) u_sltu (
    .i_rs1_data (i_op_a),
    .i_rs2_data (i_op_b),
    .i_br_un    (1'b1),
    .o_br_less  (sltu),
    .o_br_equal ()
  );

  // ========================================
  // Result select
  // ========================================
  always_comb begin
    case (i_alu_op)
      ALU_ADD:  o_alu_data = rd_add;
      ALU_SUB:  o_alu_data = rd_sub;
      ALU_SLL,
      ALU_SRA,
      ALU_SRL:  o_alu_data = rd_shift;
      ALU_SLT:  o_alu_data = {{(XLEN-1){1'b0}}, slt};
      ALU_SLTU: o_alu_data = {{(XLEN-1){1'b0}}, sltu};
      ALU_XOR:  o_alu_data = rd_xor;
      ALU_OR:   o_alu_data = rd_or;
      ALU_AND:  o_alu_data = rd_and;
      default:  o_alu_data = '0;  // Codes 10 to 15
    endcase
  end

endmodule

// ==== design/brcomp.sv ====
`timescale 1ns/1ns

module brcomp #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic            i_br_un,     // High for unsigned compare
  output logic            o_br_less,
  output logic            o_br_equal
);

  logic [XLEN-1:0] diff;
  logic            carry;      // Set when rs1 >= rs2 as unsigned
  logic            sign_diff;  // Operand signs disagree

  // rs1 - rs2 as rs1 + ~rs2 + 1, keeping the carry out
  assign {carry, diff} = {1'b0, i_rs1_data} + {1'b0, ~i_rs2_data}
                       + {{XLEN{1'b0}}, 1'b1};

  assign sign_diff = i_rs1_data[XLEN-1] ^ i_rs2_data[XLEN-1];

  // Signed order flips the unsigned one when the signs differ
  assign o_br_less  = i_br_un ? ~carry : (~carry ^ sign_diff);
  assign o_br_equal = (diff == '0);

endmodule

// ==== design/exec_core.sv ====
`timescale 1ns/1ns

module exec_core import rv_exec_pkg::*; #(
  parameter int XLEN = rv_exec_pkg::XLEN
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_instr_vld,
  input  logic [31:0]     i_instr,
  output logic            o_rd_wr,
  output logic [4:0]      o_rd_addr,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_br_vld,
  output logic            o_br_taken
);

  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [31:0]     imm;
  alu_op_e         alu_op;
  logic            use_imm;
  logic            rd_we;
  logic            is_branch;
  logic            br_unsigned;
  logic [1:0]      br_funct;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] op_b;
  logic            br_less;
  logic            br_equal;

  inst_decoder u_inst_decoder (
    .i_instr       (i_instr),
    .o_rs1_addr    (rs1_addr),
    .o_rs2_addr    (rs2_addr),
    .o_rd_addr     (o_rd_addr),
    .o_imm         (imm),
    .o_alu_op      (alu_op),
    .o_use_imm     (use_imm),
    .o_rd_we       (rd_we),
    .o_is_branch   (is_branch),
    .o_br_unsigned (br_unsigned),
    .o_br_funct    (br_funct)
  );

  assign o_rd_wr  = rd_we & i_instr_vld;
  assign o_br_vld = is_branch & i_instr_vld;

  regfile #(.XLEN(XLEN)) u_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_we      (o_rd_wr),
    .i_waddr   (o_rd_addr),
    .i_wdata   (o_rd_data),
    .i_raddr_a (rs1_addr),
    .i_raddr_b (rs2_addr),
    .o_rdata_a (rs1_data),
    .o_rdata_b (rs2_data)
  );

  assign op_b = use_imm ? XLEN'(signed'(imm)) : rs2_data;  // Sign-extended immediate

  alu #(.XLEN(XLEN)) u_alu (
    .i_op_a     (rs1_data),
    .i_op_b     (op_b),
    .i_alu_op   (alu_op),
    .o_alu_data (o_rd_data)
  );

  // Branch compare always on the two register values
  brcomp #(.XLEN(XLEN)) u_brcomp (
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_br_un    (br_unsigned),
    .o_br_less  (br_less),
    .o_br_equal (br_equal)
  );

  always_comb begin
    case (br_funct)
      2'd0:    o_br_taken = br_equal;   // BEQ
      2'd1:    o_br_taken = ~br_equal;  // BNE
      2'd2:    o_br_taken = br_less;    // BLT, BLTU
      default: o_br_taken = ~br_less;   // BGE, BGEU
    endcase
  end

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder import rv_exec_pkg::*; (
  input  logic [31:0] i_instr,
  output logic [4:0]  o_rs1_addr,
  output logic [4:0]  o_rs2_addr,
  output logic [4:0]  o_rd_addr,
  output logic [31:0] o_imm,
  output alu_op_e     o_alu_op,
  output logic        o_use_imm,
  output logic        o_rd_we,
  output logic        o_is_branch,
  output logic        o_br_unsigned,
  output logic [1:0]  o_br_funct     // 0 eq, 1 ne, 2 lt, 3 ge
);

  inst_u       instr;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic        is_op;
  logic        is_op_imm;
  logic        is_br_opc;
  logic        br_ok;      // Known branch funct3
  logic        alt_fn;     // SUB/SRA select

  assign instr      = i_instr;
  assign o_rs1_addr = instr.r_view.rs1;
  assign o_rs2_addr = instr.r_view.rs2;
  assign o_rd_addr  = instr.r_view.rd;

  assign is_op     = (instr.r_view.opcode == OPC_OP);
  assign is_op_imm = (instr.r_view.opcode == OPC_OP_IMM);
  assign is_br_opc = (instr.b_view.opcode == OPC_BRANCH);

  // ========================================
  // Immediates
  // ========================================
  assign imm_i = {{20{instr.r_view.funct7[6]}}, instr.r_view.funct7, instr.r_view.rs2};
  assign imm_b = {{19{instr.b_view.imm12}}, instr.b_view.imm12, instr.b_view.imm11,
                  instr.b_view.imm10_5, instr.b_view.imm4_1, 1'b0};

  assign o_imm     = is_br_opc ? imm_b : imm_i;
  assign o_use_imm = is_op_imm;
  assign o_rd_we   = (is_op | is_op_imm) & (instr.r_view.rd != 5'd0);  // No x0 writes

  // Bit 30 picks SUB or SRA and is imm[10] in SRAI
  assign alt_fn = instr.r_view.funct7[5];

  always_comb begin
    o_alu_op = ALU_ADD;
    case (instr.r_view.funct3)
      F3_ADD: begin
        if (is_op && alt_fn) begin
          o_alu_op = ALU_SUB;  // No SUBI
        end
      end
      F3_SLL:  o_alu_op = ALU_SLL;
      F3_SLT:  o_alu_op = ALU_SLT;
      F3_SLTU: o_alu_op = ALU_SLTU;
      F3_XOR:  o_alu_op = ALU_XOR;
      F3_SR: begin
        if (alt_fn) begin
          o_alu_op = ALU_SRA;
        end else begin
          o_alu_op = ALU_SRL;
        end
      end
      F3_OR:   o_alu_op = ALU_OR;
      F3_AND:  o_alu_op = ALU_AND;
      default: o_alu_op = ALU_ADD;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    br_ok         = 1'b1;
    o_br_unsigned = 1'b0;
    o_br_funct    = 2'd0;
    case (instr.b_view.funct3)
      F3_BEQ:  o_br_funct = 2'd0;
      F3_BNE:  o_br_funct = 2'd1;
      F3_BLT:  o_br_funct = 2'd2;
      F3_BGE:  o_br_funct = 2'd3;
      F3_BLTU: begin
        o_br_funct    = 2'd2;
        o_br_unsigned = 1'b1;
      end
      F3_BGEU: begin
        o_br_funct    = 2'd3;
        o_br_unsigned = 1'b1;
      end
      default: br_ok = 1'b0;  // 010 and 011 are reserved
    endcase
  end

  assign o_is_branch = is_br_opc & br_ok;

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ns

module regfile #(
  parameter int XLEN = 32
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_we,
  input  logic [4:0]      i_waddr,
  input  logic [XLEN-1:0] i_wdata,
  input  logic [4:0]      i_raddr_a,
  input  logic [4:0]      i_raddr_b,
  output logic [XLEN-1:0] o_rdata_a,
  output logic [XLEN-1:0] o_rdata_b
);

  // x1..x31 only, x0 reads as zero
  logic [XLEN-1:0] regs [1:31];

  // ========================================
  // Write port
  // ========================================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != 5'd0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // ========================================
  // Read ports
  // ========================================
  assign o_rdata_a = (i_raddr_a == 5'd0) ? '0 : regs[i_raddr_a];
  assign o_rdata_b = (i_raddr_b == 5'd0) ? '0 : regs[i_raddr_b];

endmodule

// ==== design/rv_exec_pkg.sv ====
package rv_exec_pkg;

  // ========================================
  // Widths and opcodes
  // ========================================
  localparam int XLEN = 32;

  localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Funct3 for OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;  // ADD, SUB, ADDI
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL, SRA and immediate forms
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Funct3 for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ========================================
  // Operation codes
  // ========================================
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRA  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    SH_SLL = 2'd0,
    SH_SRL = 2'd1,
    SH_SRA = 2'd2
  } shift_op_e;

  // One instruction word, seen as R/I-type or as B-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;  // imm[11:5] for I-type
      logic [4:0] rs2;     // imm[4:0] for I-type
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_view;
  } inst_u;

endpackage

// ==== design/shifter.sv ====
`timescale 1ns/1ns

module shifter import rv_exec_pkg::*; #(
  parameter  int XLEN = rv_exec_pkg::XLEN,
  localparam int SHW  = $clog2(XLEN)
) (
  input  logic [XLEN-1:0] i_data,
  input  logic [SHW-1:0]  i_shamt,
  input  shift_op_e       i_shift_op,
  output logic [XLEN-1:0] o_data
);

  logic [XLEN-1:0] src;              // Reversed for left shifts
  logic [XLEN-1:0] stage [0:SHW];
  logic            fill;

  // Left shift reuses the right shifter on bit-reversed data
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      src[i] = (i_shift_op == SH_SLL) ? i_data[XLEN-1-i] : i_data[i];
    end
  end

  assign fill     = (i_shift_op == SH_SRA) & i_data[XLEN-1];  // Sign fill for SRA only
  assign stage[0] = src;

  // One stage per shift-amount bit
  for (genvar k = 0; k < SHW; k++) begin : g_stage
    localparam int STEP = 1 << k;
    assign stage[k+1] = i_shamt[k] ? {{STEP{fill}}, stage[k][XLEN-1:STEP]} : stage[k];
  end

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      o_data[i] = (i_shift_op == SH_SLL) ? stage[SHW][XLEN-1-i] : stage[SHW][i];
    end
  end

endmodule

// ==== sources.f ====
design/rv_exec_pkg.sv
design/brcomp.sv
design/shifter.sv
design/alu.sv
design/inst_decoder.sv
design/regfile.sv
design/exec_core.sv
test/tb_exec_core.sv

// ==== test/tb_exec_core.sv ====
`timescale 1ns/1ns

module tb_exec_core import rv_exec_pkg::*; ();

  localparam int HALF_PERIOD = 20;
  localparam int SETTLE      = 10;  // After the falling edge, before the rising one
  localparam int IDLE_LIMIT  = 10;

  typedef struct packed {
    logic [31:0] instr;
    logic        wr;
    logic [4:0]  addr;
    logic [31:0] data;
    logic        br_vld;
    logic        taken;
  } entry_t;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_instr_vld;
  logic [31:0] i_instr;
  logic        o_rd_wr;
  logic [4:0]  o_rd_addr;
  logic [31:0] o_rd_data;
  logic        o_br_vld;
  logic        o_br_taken;

  entry_t vectors_q[$];

  exec_core #(.XLEN(XLEN)) u_exec_core (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_instr_vld (i_instr_vld),
    .i_instr     (i_instr),
    .o_rd_wr     (o_rd_wr),
    .o_rd_addr   (o_rd_addr),
    .o_rd_data   (o_rd_data),
    .o_br_vld    (o_br_vld),
    .o_br_taken  (o_br_taken)
  );

  always #HALF_PERIOD i_clk = ~i_clk;

  // ========================================
  // Instruction encoding
  // ========================================
  function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  // Fixed offset of +16, only the outcome matters here
  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    return {1'b0, 6'b0, rs2, rs1, f3, 4'b1000, 1'b0, OPC_BRANCH};
  endfunction

  task automatic add_write(input logic [31:0] instr, input logic [4:0] rd,
                           input logic [31:0] data);
    entry_t e;
    e = '{instr: instr, wr: 1'b1, addr: rd, data: data, br_vld: 1'b0, taken: 1'b0};
    vectors_q.push_back(e);
  endtask

  task automatic add_skip(input logic [31:0] instr);  // Valid but no write
    entry_t e;
    e = '{instr: instr, wr: 1'b0, addr: 5'd0, data: '0, br_vld: 1'b0, taken: 1'b0};
    vectors_q.push_back(e);
  endtask

  task automatic add_branch(input logic [31:0] instr, input logic taken);
    entry_t e;
    e = '{instr: instr, wr: 1'b0, addr: 5'd0, data: '0, br_vld: 1'b1, taken: taken};
    vectors_q.push_back(e);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  // ========================================
  // Stimulus table
  // ========================================
  task automatic load_vectors();
    add_write(op_word(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3), 5'd3, 32'h0000_0000);  // Cleared regs
    add_write(imm_word(12'h064, 5'd0, F3_ADD, 5'd1), 5'd1, 32'h0000_0064);      // x1 = 100
    add_write(imm_word(12'hFF9, 5'd0, F3_ADD, 5'd2), 5'd2, 32'hFFFF_FFF9);      // x2 = -7
    add_write(op_word(7'h00, 5'd2, 5'd1, F3_ADD, 5'd6), 5'd6, 32'h0000_005D);   // Readback
    add_write(imm_word(12'h7FF, 5'd0, F3_ADD, 5'd4), 5'd4, 32'h0000_07FF);
    add_write(imm_word(12'h800, 5'd0, F3_ADD, 5'd5), 5'd5, 32'hFFFF_F800);
    add_write(imm_word(12'h024, 5'd0, F3_ADD, 5'd12), 5'd12, 32'h0000_0024);    // Shift 36
    add_write(op_word(7'h00, 5'd5, 5'd4, F3_ADD, 5'd28), 5'd28, 32'hFFFF_FFFF);
    // OP functions
    add_write(op_word(7'h20, 5'd1, 5'd2, F3_ADD, 5'd7), 5'd7, 32'hFFFF_FF95);
    add_write(op_word(7'h20, 5'd1, 5'd0, F3_ADD, 5'd8), 5'd8, 32'hFFFF_FF9C);   // Wraps
    add_write(op_word(7'h00, 5'd1, 5'd2, F3_SLT, 5'd9), 5'd9, 32'h0000_0001);
    add_write(op_word(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd10), 5'd10, 32'h0000_0000);
    add_write(op_word(7'h00, 5'd12, 5'd1, F3_SLL, 5'd11), 5'd11, 32'h0000_0640);
    add_write(op_word(7'h00, 5'd2, 5'd1, F3_XOR, 5'd13), 5'd13, 32'hFFFF_FF9D);
    add_write(op_word(7'h00, 5'd12, 5'd2, F3_SR, 5'd14), 5'd14, 32'h0FFF_FFFF);  // SRL
    add_write(op_word(7'h20, 5'd12, 5'd2, F3_SR, 5'd15), 5'd15, 32'hFFFF_FFFF);  // SRA
    add_write(op_word(7'h00, 5'd2, 5'd1, F3_OR, 5'd16), 5'd16, 32'hFFFF_FFFD);
    add_write(op_word(7'h00, 5'd2, 5'd1, F3_AND, 5'd17), 5'd17, 32'h0000_0060);
    // OP-IMM functions
    add_write(imm_word(12'hFFA, 5'd2, F3_SLT, 5'd18), 5'd18, 32'h0000_0001);
    add_write(imm_word(12'hFFF, 5'd1, F3_SLTU, 5'd19), 5'd19, 32'h0000_0001);
    add_write(imm_word(12'h005, 5'd2, F3_SLTU, 5'd20), 5'd20, 32'h0000_0000);
    add_write(imm_word(12'hFFF, 5'd1, F3_XOR, 5'd21), 5'd21, 32'hFFFF_FF9B);
    add_write(imm_word(12'h0F0, 5'd1, F3_OR, 5'd22), 5'd22, 32'h0000_00F4);
    add_write(imm_word(12'h0FF, 5'd2, F3_AND, 5'd23), 5'd23, 32'h0000_00F9);
    add_write(imm_word(12'h003, 5'd1, F3_SLL, 5'd24), 5'd24, 32'h0000_0320);
    add_write(imm_word(12'h004, 5'd5, F3_SR, 5'd25), 5'd25, 32'h0FFF_FF80);   // SRLI
    add_write(imm_word(12'h404, 5'd5, F3_SR, 5'd26), 5'd26, 32'hFFFF_FF80);   // SRAI
    // x0 stays zero
    add_skip(imm_word(12'h005, 5'd1, F3_ADD, 5'd0));
    add_write(op_word(7'h00, 5'd0, 5'd0, F3_ADD, 5'd27), 5'd27, 32'h0000_0000);
    // Branches, x1 = 100 and x2 = -7
    add_branch(branch_word(F3_BEQ, 5'd1, 5'd1), 1'b1);
    add_branch(branch_word(F3_BEQ, 5'd1, 5'd2), 1'b0);
    add_branch(branch_word(F3_BNE, 5'd1, 5'd2), 1'b1);
    add_branch(branch_word(F3_BNE, 5'd2, 5'd2), 1'b0);
    add_branch(branch_word(F3_BLT, 5'd2, 5'd1), 1'b1);
    add_branch(branch_word(F3_BLT, 5'd1, 5'd2), 1'b0);
    add_branch(branch_word(F3_BGE, 5'd1, 5'd2), 1'b1);
    add_branch(branch_word(F3_BGE, 5'd2, 5'd1), 1'b0);
    add_branch(branch_word(F3_BLTU, 5'd1, 5'd2), 1'b1);  // Unsigned disagrees with signed
    add_branch(branch_word(F3_BLTU, 5'd2, 5'd1), 1'b0);
    add_branch(branch_word(F3_BGEU, 5'd2, 5'd1), 1'b1);
    add_branch(branch_word(F3_BGEU, 5'd1, 5'd2), 1'b0);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    entry_t e;
    int     idle_cycles;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_instr_vld = 1'b0;
    i_instr     = '0;
    load_vectors();

    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    // Outputs must go quiet with no valid instruction
    idle_cycles = 0;
    while ((o_rd_wr !== 1'b0) || (o_br_vld !== 1'b0)) begin
      if (idle_cycles == IDLE_LIMIT) begin
        $display("Write and branch valid did not go low after reset");
        $display(">>> FAIL");
        $fatal(1, "Idle wait timed out");
      end
      @(negedge i_clk);
      idle_cycles++;
    end

    foreach (vectors_q[i]) begin
      e = vectors_q[i];
      if (i > 0) begin
        @(negedge i_clk);
      end
      i_instr_vld = 1'b1;
      i_instr     = e.instr;
      #SETTLE;
      check_value("o_rd_wr", e.wr, o_rd_wr);
      check_value("o_br_vld", e.br_vld, o_br_vld);
      if (e.wr) begin
        check_value("o_rd_addr", e.addr, o_rd_addr);
        check_value("o_rd_data", e.data, o_rd_data);
      end
      if (e.br_vld) begin
        check_value("o_br_taken", e.taken, o_br_taken);
      end
    end

    @(negedge i_clk);
    i_instr_vld = 1'b0;
    i_instr     = '0;
    #SETTLE;
    check_value("o_rd_wr", 1'b0, o_rd_wr);
    check_value("o_br_vld", 1'b0, o_br_vld);

    $display(">>> PASS");
    $finish;
  end

endmodule
